// File: hdl/opp_defs.svh
`ifndef OPP_DEFS_SVH
`define OPP_DEFS_SVH

////////////////////////////////////////////////////////////
// sizes
////////////////////////////////////////////////////////////

// output channels fed by the pid stream
`define OPP_N_CHAN 4
// widths of sample, multiplier, shift and dac code
`define OPP_W_SAMPLE 18
`define OPP_W_MULT 16
`define OPP_W_RS 5
`define OPP_W_DAC 16
// dac instruction queue capacity in words
`define OPP_FIFO_DEPTH 8

////////////////////////////////////////////////////////////
// register map
////////////////////////////////////////////////////////////

`define OPP_AXI_W_ADDR 8
// each field holds one 32-bit word per channel
`define OPP_MULT_BASE 'h00
`define OPP_RS_BASE 'h10
`define OPP_MIN_BASE 'h20
`define OPP_MAX_BASE 'h30
`define OPP_STATUS_ADDR 'h40

`endif

// File: hdl/opp_pkg.sv
`include "opp_defs.svh"

package opp_pkg;

	////////////////////////////////////////////////////////////
	// scalar types
	////////////////////////////////////////////////////////////

	typedef logic [$clog2(`OPP_N_CHAN)-1:0] chan_t;
	typedef logic signed [`OPP_W_SAMPLE-1:0] sample_t;
	typedef logic signed [`OPP_W_MULT-1:0] mult_t;
	typedef logic [`OPP_W_RS-1:0] rshift_t;
	typedef logic [`OPP_W_DAC-1:0] dac_t;

	////////////////////////////////////////////////////////////
	// per-channel tables, element i belongs to channel i
	////////////////////////////////////////////////////////////

	typedef mult_t [`OPP_N_CHAN-1:0] mult_tab_t;
	typedef rshift_t [`OPP_N_CHAN-1:0] rshift_tab_t;
	typedef dac_t [`OPP_N_CHAN-1:0] dac_tab_t;

	// one dac instruction, channel in the upper bits
	typedef struct packed {
		chan_t chan;
		dac_t code;
	} dac_word_t;

endpackage

// File: hdl/opp_axil_regs.sv
`timescale 1ns/1ps
`include "opp_defs.svh"

module opp_axil_regs (
	input logic sys_clk_in,
	input logic sys_reset,
	// write address and data
	input logic [`OPP_AXI_W_ADDR-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	// write response
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	// read address and data
	input logic [`OPP_AXI_W_ADDR-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	// dropped-word pulse from the queue
	input logic overflow,
	// per-channel tables
	output opp_pkg::mult_tab_t mult_tab,
	output opp_pkg::rshift_tab_t rshift_tab,
	output opp_pkg::dac_tab_t min_tab,
	output opp_pkg::dac_tab_t max_tab
);

	// bytes covered by one field, one word per channel
	localparam int SPAN = 4 * `OPP_N_CHAN;
	localparam int W_CHAN = $bits(opp_pkg::chan_t);

	typedef enum logic [2:0] {F_NONE, F_MULT, F_RS, F_MIN, F_MAX, F_STATUS} field_e;

	field_e wr_field;
	field_e rd_field;
	opp_pkg::chan_t wr_chan;
	opp_pkg::chan_t rd_chan;
	logic wr_hs;
	logic rd_hs;
	logic ovf_sticky;
	logic [31:0] rd_word;

	// split an address into field and channel
	function automatic void decode(input logic [`OPP_AXI_W_ADDR-1:0] addr,
			output field_e field, output opp_pkg::chan_t chan);
		logic [`OPP_AXI_W_ADDR-1:0] offset;
		field = F_NONE;
		offset = '0;
		if (addr == `OPP_STATUS_ADDR) begin
			field = F_STATUS;
		end else if (addr >= `OPP_MULT_BASE && addr < `OPP_MULT_BASE + SPAN) begin
			field = F_MULT;
			offset = addr - `OPP_MULT_BASE;
		end else if (addr >= `OPP_RS_BASE && addr < `OPP_RS_BASE + SPAN) begin
			field = F_RS;
			offset = addr - `OPP_RS_BASE;
		end else if (addr >= `OPP_MIN_BASE && addr < `OPP_MIN_BASE + SPAN) begin
			field = F_MIN;
			offset = addr - `OPP_MIN_BASE;
		end else if (addr >= `OPP_MAX_BASE && addr < `OPP_MAX_BASE + SPAN) begin
			field = F_MAX;
			offset = addr - `OPP_MAX_BASE;
		end
		// word index inside the field
		chan = offset[2 +: W_CHAN];
	endfunction

	always_comb begin
		decode(awaddr, wr_field, wr_chan);
		decode(araddr, rd_field, rd_chan);
	end

	assign wr_hs = awvalid && awready && wvalid && wready;
	assign rd_hs = arvalid && arready;

	// responses are always okay, unmapped space included
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	////////////////////////////////////////////////////////////
	// write channel and tables
	////////////////////////////////////////////////////////////

	// wstrb not decoded, every write replaces the whole field
	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			ovf_sticky <= 1'b0;
			for (int i = 0; i < `OPP_N_CHAN; i++) begin
				mult_tab[i] <= opp_pkg::mult_t'(1);
				rshift_tab[i] <= '0;
				min_tab[i] <= '0;
				max_tab[i] <= '1;
			end
		end else begin
			// ready is a one-cycle pulse
			awready <= 1'b0;
			wready <= 1'b0;
			if (awvalid && wvalid && !bvalid && !awready) begin
				awready <= 1'b1;
				wready <= 1'b1;
			end
			if (wr_hs) begin
				bvalid <= 1'b1;
				case (wr_field)
					F_MULT: mult_tab[wr_chan] <= wdata[`OPP_W_MULT-1:0];
					F_RS: rshift_tab[wr_chan] <= wdata[`OPP_W_RS-1:0];
					F_MIN: min_tab[wr_chan] <= wdata[`OPP_W_DAC-1:0];
					F_MAX: max_tab[wr_chan] <= wdata[`OPP_W_DAC-1:0];
					// any write clears the flag
					F_STATUS: ovf_sticky <= 1'b0;
					F_NONE: ;
					default: ;
				endcase
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			// a new drop wins over a clear in the same cycle
			if (overflow) begin
				ovf_sticky <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// read channel
	////////////////////////////////////////////////////////////

	// fields come back zero-extended
	always_comb begin
		rd_word = '0;
		case (rd_field)
			F_MULT: rd_word[`OPP_W_MULT-1:0] = mult_tab[rd_chan];
			F_RS: rd_word[`OPP_W_RS-1:0] = rshift_tab[rd_chan];
			F_MIN: rd_word[`OPP_W_DAC-1:0] = min_tab[rd_chan];
			F_MAX: rd_word[`OPP_W_DAC-1:0] = max_tab[rd_chan];
			F_STATUS: rd_word[0] = ovf_sticky;
			F_NONE: ;
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= 1'b0;
			if (arvalid && !rvalid && !arready) begin
				arready <= 1'b1;
			end
			if (rd_hs) begin
				rvalid <= 1'b1;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// read data held until the response is taken
	always_ff @(posedge sys_clk_in) begin
		if (rd_hs) begin
			rdata <= rd_word;
		end
	end

endmodule

// File: hdl/opp_datapath.sv
`timescale 1ns/1ps
`include "opp_defs.svh"

module opp_datapath (
	input logic sys_clk_in,
	input logic sys_reset,
	// pid result stream, no back-pressure
	input logic in_valid,
	input opp_pkg::chan_t in_chan,
	input opp_pkg::sample_t in_data,
	// per-channel configuration
	input opp_pkg::mult_tab_t mult_tab,
	input opp_pkg::rshift_tab_t rshift_tab,
	input opp_pkg::dac_tab_t min_tab,
	input opp_pkg::dac_tab_t max_tab,
	// clamped result towards the queue
	output logic res_valid,
	output opp_pkg::chan_t res_chan,
	output opp_pkg::dac_t res_data
);

	localparam int W_PROD = `OPP_W_SAMPLE + `OPP_W_MULT;

	// stage 1
	logic s1_valid;
	opp_pkg::chan_t s1_chan;
	logic signed [W_PROD-1:0] s1_prod;
	opp_pkg::rshift_t s1_rs;
	// stage 2
	logic s2_valid;
	opp_pkg::chan_t s2_chan;
	logic signed [W_PROD-1:0] s2_shift;
	// stage 3, one extra bit for the accumulate
	logic signed [W_PROD:0] acc_sum;
	logic signed [W_PROD:0] acc_hi;
	logic signed [W_PROD:0] acc_clamp;
	opp_pkg::dac_t prev_out [`OPP_N_CHAN];

	////////////////////////////////////////////////////////////
	// valid pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			s2_valid <= s1_valid;
			res_valid <= s2_valid;
		end
	end

	////////////////////////////////////////////////////////////
	// stage 1 multiply, stage 2 shift
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk_in) begin
		// signed product, fetch the shift with it
		s1_prod <= in_data * opp_pkg::mult_t'(mult_tab[in_chan]);
		s1_rs <= rshift_tab[in_chan];
		s1_chan <= in_chan;
		// arithmetic shift keeps the sign
		s2_shift <= s1_prod >>> s1_rs;
		s2_chan <= s1_chan;
	end

	////////////////////////////////////////////////////////////
	// stage 3 accumulate, clamp, writeback
	////////////////////////////////////////////////////////////

	always_comb begin
		// previous output is unsigned
		acc_sum = s2_shift + $signed({1'b0, prev_out[s2_chan]});
		// upper bound first
		acc_hi = (acc_sum > $signed({1'b0, max_tab[s2_chan]})) ?
			$signed({1'b0, max_tab[s2_chan]}) : acc_sum;
		// then lower bound, min wins over max
		acc_clamp = (acc_hi < $signed({1'b0, min_tab[s2_chan]})) ?
			$signed({1'b0, min_tab[s2_chan]}) : acc_hi;
	end

	always_ff @(posedge sys_clk_in) begin
		res_chan <= s2_chan;
		res_data <= acc_clamp[`OPP_W_DAC-1:0];
	end

	// same-cycle read and write keeps back-to-back samples right
	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			for (int i = 0; i < `OPP_N_CHAN; i++) begin
				prev_out[i] <= '0;
			end
		end else if (s2_valid) begin
			prev_out[s2_chan] <= acc_clamp[`OPP_W_DAC-1:0];
		end
	end

endmodule

// File: hdl/opp_dac_queue.sv
`timescale 1ns/1ps
`include "opp_defs.svh"

module opp_dac_queue (
	input logic sys_clk_in,
	input logic sys_reset,
	// results from the datapath
	input logic res_valid,
	input opp_pkg::chan_t res_chan,
	input opp_pkg::dac_t res_data,
	// dac word stream
	output logic dac_valid,
	output opp_pkg::chan_t dac_chan,
	output opp_pkg::dac_t dac_data,
	input logic dac_ready,
	// one-cycle pulse per dropped word
	output logic overflow
);

	localparam int W_PTR = $clog2(`OPP_FIFO_DEPTH);
	localparam int W_CNT = $clog2(`OPP_FIFO_DEPTH + 1);

	opp_pkg::dac_word_t mem [`OPP_FIFO_DEPTH];
	opp_pkg::dac_word_t head;
	logic [W_PTR-1:0] wr_ptr;
	logic [W_PTR-1:0] rd_ptr;
	logic [W_CNT-1:0] count;
	logic full;
	logic push;
	logic pop;

	assign full = (count == W_CNT'(`OPP_FIFO_DEPTH));
	// full means full, a pop in the same cycle does not make room
	assign push = res_valid && !full;
	assign pop = dac_valid && dac_ready;

	// head word stays put until it is taken
	assign head = mem[rd_ptr];
	assign dac_valid = (count != '0);
	assign dac_chan = head.chan;
	assign dac_data = head.code;

	always_ff @(posedge sys_clk_in) begin
		if (push) begin
			mem[wr_ptr] <= '{chan: res_chan, code: res_data};
		end
	end

	////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == W_PTR'(`OPP_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == W_PTR'(`OPP_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			// word lost, tell the status register
			overflow <= res_valid && full;
		end
	end

endmodule

// File: hdl/opp_top.sv
`timescale 1ns/1ps
`include "opp_defs.svh"

module opp_top (
	input logic sys_clk_in,
	input logic sys_reset,
	// axi4-lite configuration slave
	input logic [`OPP_AXI_W_ADDR-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`OPP_AXI_W_ADDR-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	// pid sample stream
	input logic in_valid,
	input opp_pkg::chan_t in_chan,
	input opp_pkg::sample_t in_data,
	// dac word stream
	output logic dac_valid,
	output opp_pkg::chan_t dac_chan,
	output opp_pkg::dac_t dac_data,
	input logic dac_ready
);

	////////////////////////////////////////////////////////////
	// internal wiring
	////////////////////////////////////////////////////////////

	opp_pkg::mult_tab_t mult_tab;
	opp_pkg::rshift_tab_t rshift_tab;
	opp_pkg::dac_tab_t min_tab;
	opp_pkg::dac_tab_t max_tab;
	logic res_valid;
	opp_pkg::chan_t res_chan;
	opp_pkg::dac_t res_data;
	logic overflow;

	// decode, register file behind axi
	opp_axil_regs u_regs (
		.sys_clk_in (sys_clk_in),
		.sys_reset  (sys_reset),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.overflow   (overflow),
		.mult_tab   (mult_tab),
		.rshift_tab (rshift_tab),
		.min_tab    (min_tab),
		.max_tab    (max_tab)
	);

	// execute, multiply shift accumulate clamp
	opp_datapath u_datapath (
		.sys_clk_in (sys_clk_in),
		.sys_reset  (sys_reset),
		.in_valid   (in_valid),
		.in_chan    (in_chan),
		.in_data    (in_data),
		.mult_tab   (mult_tab),
		.rshift_tab (rshift_tab),
		.min_tab    (min_tab),
		.max_tab    (max_tab),
		.res_valid  (res_valid),
		.res_chan   (res_chan),
		.res_data   (res_data)
	);

	// result, dac instruction queue
	opp_dac_queue u_queue (
		.sys_clk_in (sys_clk_in),
		.sys_reset  (sys_reset),
		.res_valid  (res_valid),
		.res_chan   (res_chan),
		.res_data   (res_data),
		.dac_valid  (dac_valid),
		.dac_chan   (dac_chan),
		.dac_data   (dac_data),
		.dac_ready  (dac_ready),
		.overflow   (overflow)
	);

endmodule

// File: testbench/opp_tb_asserts.sv
`timescale 1ns/1ps

module opp_tb_asserts (
	input logic sys_clk_in,
	input logic sys_reset,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic dac_valid,
	input logic dac_ready,
	input opp_pkg::chan_t dac_chan,
	input opp_pkg::dac_t dac_data
);

	// failed assertions so far, watched by the testbench
	int fail_count = 0;

	// a response stays up until the master takes it
	property hold_until_taken(logic v, logic r);
		@(posedge sys_clk_in) disable iff (sys_reset) v && !r |=> v;
	endproperty

	a_bvalid_hold: assert property (hold_until_taken(bvalid, bready))
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	a_rvalid_hold: assert property (hold_until_taken(rvalid, rready))
		else begin
			$error("rvalid dropped before rready");
			fail_count++;
		end

	// stalled dac word must not move
	a_dac_stable: assert property (@(posedge sys_clk_in) disable iff (sys_reset)
			dac_valid && !dac_ready |=> dac_valid && $stable(dac_chan) && $stable(dac_data))
		else begin
			$error("dac word changed while stalled");
			fail_count++;
		end

	// queue comes out of reset empty
	a_dac_reset: assert property (@(posedge sys_clk_in) sys_reset |=> !dac_valid)
		else begin
			$error("dac_valid high after reset");
			fail_count++;
		end

endmodule

bind opp_top opp_tb_asserts u_asserts (
	.sys_clk_in (sys_clk_in),
	.sys_reset  (sys_reset),
	.bvalid     (bvalid),
	.bready     (bready),
	.rvalid     (rvalid),
	.rready     (rready),
	.dac_valid  (dac_valid),
	.dac_ready  (dac_ready),
	.dac_chan   (dac_chan),
	.dac_data   (dac_data)
);

// File: testbench/opp_tb.sv
`timescale 1ns/1ps
`include "opp_defs.svh"

module opp_tb;

	localparam int PERIOD = 40;
	localparam int TIMEOUT = 200;
	localparam logic [31:0] SEED = 32'h083baf87;

	logic sys_clk_in;
	logic sys_reset;
	logic [`OPP_AXI_W_ADDR-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`OPP_AXI_W_ADDR-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic in_valid;
	opp_pkg::chan_t in_chan;
	opp_pkg::sample_t in_data;
	logic dac_valid;
	opp_pkg::chan_t dac_chan;
	opp_pkg::dac_t dac_data;
	logic dac_ready;

	// reference model state, tables kept zero-extended
	logic [31:0] lfsr_state;
	logic [15:0] mult_m [`OPP_N_CHAN];
	logic [4:0] rs_m [`OPP_N_CHAN];
	logic [15:0] min_m [`OPP_N_CHAN];
	logic [15:0] max_m [`OPP_N_CHAN];
	logic [15:0] prev_m [`OPP_N_CHAN];
	// expected words, chan above code
	logic [17:0] exp_q [$];
	logic [17:0] exp_word;

	opp_top u_dut (.*);

	always #(PERIOD / 2) sys_clk_in = ~sys_clk_in;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	// one clock, give up after TIMEOUT of them
	task automatic wait_cycle(inout int t, input string what);
		@(posedge sys_clk_in);
		t++;
		if (t > TIMEOUT) begin
			$display("timeout waiting for %s", what);
			abort_run();
		end
	endtask

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// field 0 mult, 1 shift, 2 min, 3 max
	function automatic logic [7:0] field_addr(input int f, input int ch);
		case (f)
			0: return `OPP_MULT_BASE + 4 * ch;
			1: return `OPP_RS_BASE + 4 * ch;
			2: return `OPP_MIN_BASE + 4 * ch;
			default: return `OPP_MAX_BASE + 4 * ch;
		endcase
	endfunction

	function automatic logic [31:0] field_value(input int f, input int ch);
		case (f)
			0: return 32'(mult_m[ch]);
			1: return 32'(rs_m[ch]);
			2: return 32'(min_m[ch]);
			default: return 32'(max_m[ch]);
		endcase
	endfunction

	// multiply, arithmetic shift, accumulate, max then min
	function automatic logic [15:0] model_step(input int ch, input logic [17:0] s);
		longint prod;
		longint acc;
		prod = longint'($signed(s)) * longint'($signed(mult_m[ch]));
		acc = (prod >>> rs_m[ch]) + longint'(prev_m[ch]);
		if (acc > longint'(max_m[ch])) acc = max_m[ch];
		if (acc < longint'(min_m[ch])) acc = min_m[ch];
		// dropped words still count here
		prev_m[ch] = acc[15:0];
		return acc[15:0];
	endfunction

	////////////////////////////////////////////////////////////
	// axi4-lite master
	////////////////////////////////////////////////////////////

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
		int t;
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		t = 0;
		do begin
			wait_cycle(t, "awready and wready");
		end while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		t = 0;
		do begin
			wait_cycle(t, "bvalid");
		end while (!bvalid);
		check("bresp", bresp, 2'b00);
		// let the response wait a few cycles before taking it
		repeat (rand_bits(2)) @(posedge sys_clk_in);
		bready <= 1'b1;
		@(posedge sys_clk_in);
		bready <= 1'b0;
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
		int t;
		araddr <= addr;
		arvalid <= 1'b1;
		t = 0;
		do begin
			wait_cycle(t, "arready");
		end while (!arready);
		arvalid <= 1'b0;
		t = 0;
		do begin
			wait_cycle(t, "rvalid");
		end while (!rvalid);
		check($sformatf("rdata at 0x%0h", addr), rdata, exp);
		check("rresp", rresp, 2'b00);
		// data has to sit still until rready
		repeat (rand_bits(2)) @(posedge sys_clk_in);
		rready <= 1'b1;
		@(posedge sys_clk_in);
		rready <= 1'b0;
	endtask

	// write a field and keep the model truncated the same way
	task automatic set_field(input int f, input int ch, input logic [31:0] v);
		axi_write(field_addr(f, ch), v);
		case (f)
			0: mult_m[ch] = v[`OPP_W_MULT-1:0];
			1: rs_m[ch] = v[`OPP_W_RS-1:0];
			2: min_m[ch] = v[`OPP_W_DAC-1:0];
			default: max_m[ch] = v[`OPP_W_DAC-1:0];
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// sample stream
	////////////////////////////////////////////////////////////

	task automatic send_sample(input int ch, input logic [17:0] s);
		logic [15:0] res;
		in_valid <= 1'b1;
		in_chan <= opp_pkg::chan_t'(ch);
		in_data <= s;
		res = model_step(ch, s);
		// queue occupancy is what is still expected
		if (exp_q.size() < `OPP_FIFO_DEPTH)
			exp_q.push_back({opp_pkg::chan_t'(ch), res});
		@(posedge sys_clk_in);
	endtask

	// negative fixed_chan picks channels at random
	task automatic send_burst(input int n, input int fixed_chan);
		int ch;
		for (int i = 0; i < n; i++) begin
			ch = (fixed_chan < 0) ? int'(rand_bits(2)) : fixed_chan;
			send_sample(ch, rand_bits(`OPP_W_SAMPLE));
			// idle cycle now and then
			if (rand_bits(2) == 0) begin
				in_valid <= 1'b0;
				@(posedge sys_clk_in);
			end
		end
		in_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while (exp_q.size() != 0) begin
			wait_cycle(t, "expected dac words");
		end
		// nothing may follow the last expected word
		repeat (4) @(posedge sys_clk_in);
		check("dac_valid", dac_valid, 1'b0);
	endtask

	// scoreboard on every dac transfer
	always @(posedge sys_clk_in) begin
		if (!sys_reset && dac_valid && dac_ready) begin
			if (exp_q.size() == 0) begin
				$display("a dac word arrived when none was expected");
				abort_run();
			end else begin
				exp_word = exp_q.pop_front();
				check("dac_chan", dac_chan, exp_word[17:16]);
				check("dac_data", dac_data, exp_word[15:0]);
			end
		end
	end

	// a failed handshake assertion ends the run at once
	always @(posedge sys_clk_in) begin
		if (u_dut.u_asserts.fail_count != 0) begin
			$display("a handshake assertion failed");
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		sys_clk_in = 1'b0;
		sys_reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		in_valid = 1'b0;
		in_chan = '0;
		in_data = '0;
		dac_ready = 1'b1;
		lfsr_state = SEED;
		for (int ch = 0; ch < `OPP_N_CHAN; ch++) begin
			mult_m[ch] = 16'h0001;
			rs_m[ch] = '0;
			min_m[ch] = '0;
			max_m[ch] = 16'hffff;
			prev_m[ch] = '0;
		end
		repeat (4) @(posedge sys_clk_in);
		sys_reset <= 1'b0;
		@(posedge sys_clk_in);

		// reset values and clear status
		for (int f = 0; f < 4; f++)
			for (int ch = 0; ch < `OPP_N_CHAN; ch++)
				read_check(field_addr(f, ch), field_value(f, ch));
		read_check(`OPP_STATUS_ADDR, 32'h0);

		// random writes read back truncated
		for (int f = 0; f < 4; f++)
			for (int ch = 0; ch < `OPP_N_CHAN; ch++)
				set_field(f, ch, rand_bits(32));
		for (int f = 0; f < 4; f++)
			for (int ch = 0; ch < `OPP_N_CHAN; ch++)
				read_check(field_addr(f, ch), field_value(f, ch));
		// holes in the map
		axi_write(8'h80, rand_bits(32));
		read_check(8'h44, 32'h0);
		read_check(8'h60, 32'h0);
		read_check(8'h80, 32'h0);
		read_check(8'hfc, 32'h0);
		// a write into a hole lands in no table
		for (int f = 0; f < 4; f++)
			for (int ch = 0; ch < `OPP_N_CHAN; ch++)
				read_check(field_addr(f, ch), field_value(f, ch));

		// random gains, shifts big enough to stay mostly in range
		for (int ch = 0; ch < `OPP_N_CHAN; ch++) begin
			set_field(0, ch, rand_bits(16));
			set_field(1, ch, 10 + rand_bits(3));
			set_field(2, ch, 32'h0);
			set_field(3, ch, 32'hffff);
		end
		send_burst(40, -1);
		wait_drain();

		// narrow windows so most results clamp
		for (int ch = 0; ch < `OPP_N_CHAN; ch++) begin
			set_field(2, ch, 32'h4000 + rand_bits(12));
			set_field(3, ch, min_m[ch] + rand_bits(8));
		end
		send_burst(24, -1);
		wait_drain();
		// min above max, min wins
		set_field(2, 2, 32'h9000);
		set_field(3, 2, 32'h1000);
		send_burst(8, 2);
		wait_drain();

		// back-pressure, overfill the queue
		for (int ch = 0; ch < `OPP_N_CHAN; ch++) begin
			set_field(2, ch, 32'h0);
			set_field(3, ch, 32'hffff);
		end
		dac_ready <= 1'b0;
		send_burst(`OPP_FIFO_DEPTH + 4, -1);
		// pipeline plus queue latency
		repeat (4) @(posedge sys_clk_in);
		check("dac_valid", dac_valid, 1'b1);
		read_check(`OPP_STATUS_ADDR, 32'h1);
		dac_ready <= 1'b1;
		wait_drain();
		axi_write(`OPP_STATUS_ADDR, rand_bits(32));
		read_check(`OPP_STATUS_ADDR, 32'h0);
		// accumulation must include the dropped samples
		send_burst(20, -1);
		wait_drain();

		if (u_dut.u_asserts.fail_count != 0) begin
			$display("%0d assertion failures", u_dut.u_asserts.fail_count);
			$display("Errors found");
			$fatal(1);
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

// File: tb.f
+incdir+hdl
hdl/opp_pkg.sv
hdl/opp_axil_regs.sv
hdl/opp_datapath.sv
hdl/opp_dac_queue.sv
hdl/opp_top.sv
testbench/opp_tb_asserts.sv
testbench/opp_tb.sv
